//--- src/vmul_config.svh
// Sizing of the vector multiply unit
// Include in every file that needs a queue depth, latency or width

`ifndef VMUL_CONFIG_SVH
`define VMUL_CONFIG_SVH

// Instruction and result buffering
`define VINSN_QUEUE_DEPTH 4
`define RESULT_QUEUE_DEPTH 2

// Register stages in the SIMD multiplier
`define MUL_LAT 2

// Register file geometry and instruction bookkeeping
`define VREG_WORDS 16
`define NR_VINSN 8
`define VL_WIDTH 9

`endif

//--- src/vmul_pkg.sv
// Types shared by the vector multiply unit and its testbench
// Compile first, before any module that imports it

`include "vmul_config.svh"

package vmul_pkg;

  // Element width of one vector element
  typedef enum logic [1:0] {
    EW8  = 2'd0,
    EW16 = 2'd1,
    EW32 = 2'd2,
    EW64 = 2'd3
  } vew_e;

  // Integer multiply operations
  typedef enum logic [1:0] {
    VMUL,
    VMACC,
    VNMSAC
  } mul_op_e;

  typedef logic [63:0]           elen_t;
  typedef logic [7:0]            strb_t;
  typedef logic [2:0]            vid_t;
  typedef logic [`VL_WIDTH-1:0]  vlen_t;
  typedef logic [8:0]            vaddr_t;

  // Operation as handed over by the lane sequencer
  typedef struct packed {
    vid_t    id;
    mul_op_e op;
    vew_e    vsew;
    vlen_t   vl;
    logic [4:0] vd;
    logic    use_scalar;
    logic    use_vd;
    elen_t   scalar_op;
  } vmul_op_t;

  // Elements packed in one 64-bit word
  function automatic logic [3:0] elems_per_word(vew_e vsew);
    return 4'd8 >> vsew;
  endfunction

endpackage

//--- src/vmul_sequencer.sv
// Instruction queue of the vector multiply unit
// Tracks each instruction through issue, processing and commit, feeds
// operand words to the multiplier and reports finished instruction IDs

`include "vmul_config.svh"

module vmul_sequencer (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  // Operations from the lane sequencer
  input  vmul_pkg::vmul_op_t    op_i,
  input  logic                  op_valid_i,
  output logic                  op_ready_o,
  // Operand queues (0 = vs1, 1 = vs2, 2 = vd)
  input  vmul_pkg::elen_t       operand_i       [3],
  input  logic                  operand_valid_i [3],
  output logic                  operand_ready_o [3],
  // Multiplier input
  output logic                  mul_valid_o,
  output vmul_pkg::elen_t       mul_a_o,
  output vmul_pkg::elen_t       mul_b_o,
  output vmul_pkg::elen_t       mul_c_o,
  output vmul_pkg::mul_op_e     mul_op_o,
  output vmul_pkg::vew_e        mul_vsew_o,
  input  logic                  mul_ready_i,
  // Result queue side
  output vmul_pkg::vmul_op_t    proc_op_o,
  output vmul_pkg::vlen_t       proc_remaining_o,
  input  logic                  proc_beat_i,
  input  logic                  commit_i,
  output logic [`NR_VINSN-1:0]  vinsn_done_o
);

  import vmul_pkg::*;

  localparam int unsigned depth = `VINSN_QUEUE_DEPTH;
  localparam int unsigned pnt_w = $clog2(depth);

  vmul_op_t         vinsn_q [depth];
  logic [pnt_w-1:0] accept_pnt_q, accept_pnt_d;
  logic [pnt_w-1:0] issue_pnt_q, issue_pnt_d;
  logic [pnt_w-1:0] processing_pnt_q, processing_pnt_d;
  logic [pnt_w-1:0] commit_pnt_q, commit_pnt_d;
  logic [pnt_w:0]   issue_cnt_q, issue_cnt_d;
  logic [pnt_w:0]   processing_cnt_q, processing_cnt_d;
  logic [pnt_w:0]   commit_cnt_q, commit_cnt_d;
  // Elements still owed by the head instruction of each phase
  vlen_t            issue_rem_q, issue_rem_d;
  vlen_t            proc_rem_q, proc_rem_d;
  vlen_t            commit_rem_q, commit_rem_d;

  vmul_op_t issue_op, commit_op;
  elen_t    scalar_rep;
  logic     accept, operands_valid, issue_fire;

  function automatic logic [pnt_w-1:0] next_pnt(logic [pnt_w-1:0] pnt);
    return (pnt == pnt_w'(depth - 1)) ? '0 : pnt + 1'b1;
  endfunction

  // Elements covered by one word, clipped to what is left
  function automatic vlen_t word_step(vew_e vsew, vlen_t rem);
    vlen_t n;
    n = vlen_t'(elems_per_word(vsew));
    return (n > rem) ? rem : n;
  endfunction

  assign issue_op         = vinsn_q[issue_pnt_q];
  assign commit_op        = vinsn_q[commit_pnt_q];
  assign proc_op_o        = vinsn_q[processing_pnt_q];
  assign proc_remaining_o = proc_rem_q;

  // Full once four instructions wait for commit
  assign op_ready_o = (commit_cnt_q != (pnt_w + 1)'(depth));
  assign accept     = op_valid_i && op_ready_o;

  //////////////////////////////////////////////////
  // Operand handshake
  //////////////////////////////////////////////////

  always_comb begin
    case (issue_op.vsew)
      EW8:     scalar_rep = {8{issue_op.scalar_op[7:0]}};
      EW16:    scalar_rep = {4{issue_op.scalar_op[15:0]}};
      EW32:    scalar_rep = {2{issue_op.scalar_op[31:0]}};
      default: scalar_rep = issue_op.scalar_op;
    endcase
  end

  assign operands_valid = operand_valid_i[1] &&
                          (operand_valid_i[0] || issue_op.use_scalar) &&
                          (operand_valid_i[2] || !issue_op.use_vd);

  assign mul_valid_o = (issue_cnt_q != '0) && operands_valid;
  assign issue_fire  = mul_valid_o && mul_ready_i;
  assign mul_a_o     = issue_op.use_scalar ? scalar_rep : operand_i[0];
  assign mul_b_o     = operand_i[1];
  assign mul_c_o     = operand_i[2];
  assign mul_op_o    = issue_op.op;
  assign mul_vsew_o  = issue_op.vsew;

  // Pop only the queues this instruction reads
  assign operand_ready_o[0] = issue_fire && !issue_op.use_scalar;
  assign operand_ready_o[1] = issue_fire;
  assign operand_ready_o[2] = issue_fire && issue_op.use_vd;

  //////////////////////////////////////////////////
  // Phase pointers and element counters
  //////////////////////////////////////////////////

  always_comb begin
    accept_pnt_d     = accept_pnt_q;
    issue_pnt_d      = issue_pnt_q;
    processing_pnt_d = processing_pnt_q;
    commit_pnt_d     = commit_pnt_q;
    issue_cnt_d      = issue_cnt_q;
    processing_cnt_d = processing_cnt_q;
    commit_cnt_d     = commit_cnt_q;
    issue_rem_d      = issue_rem_q;
    proc_rem_d       = proc_rem_q;
    commit_rem_d     = commit_rem_q;
    vinsn_done_o     = '0;

    if (issue_fire) begin
      issue_rem_d = issue_rem_q - word_step(issue_op.vsew, issue_rem_q);
      if (issue_rem_d == '0) begin
        issue_cnt_d = issue_cnt_q - 1'b1;
        issue_pnt_d = next_pnt(issue_pnt_q);
        if (issue_cnt_d != '0) issue_rem_d = vinsn_q[issue_pnt_d].vl;
      end
    end

    if (proc_beat_i) begin
      proc_rem_d = proc_rem_q - word_step(proc_op_o.vsew, proc_rem_q);
      if (proc_rem_d == '0) begin
        processing_cnt_d = processing_cnt_q - 1'b1;
        processing_pnt_d = next_pnt(processing_pnt_q);
        if (processing_cnt_d != '0) proc_rem_d = vinsn_q[processing_pnt_d].vl;
      end
    end

    // Last word granted, so the instruction retires in this cycle
    if (commit_i) begin
      commit_rem_d = commit_rem_q - word_step(commit_op.vsew, commit_rem_q);
      if (commit_rem_d == '0) begin
        vinsn_done_o[commit_op.id] = 1'b1;
        commit_cnt_d = commit_cnt_q - 1'b1;
        commit_pnt_d = next_pnt(commit_pnt_q);
        if (commit_cnt_d != '0) commit_rem_d = vinsn_q[commit_pnt_d].vl;
      end
    end

    // A phase with nothing left starts on the new instruction
    if (accept) begin
      if (issue_cnt_d == '0) issue_rem_d = op_i.vl;
      if (processing_cnt_d == '0) proc_rem_d = op_i.vl;
      if (commit_cnt_d == '0) commit_rem_d = op_i.vl;
      accept_pnt_d     = next_pnt(accept_pnt_q);
      issue_cnt_d      = issue_cnt_d + 1'b1;
      processing_cnt_d = processing_cnt_d + 1'b1;
      commit_cnt_d     = commit_cnt_d + 1'b1;
    end
  end

  always_ff @(posedge clk_i) begin
    if (accept) begin
      vinsn_q[accept_pnt_q] <= op_i;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      accept_pnt_q     <= '0;
      issue_pnt_q      <= '0;
      processing_pnt_q <= '0;
      commit_pnt_q     <= '0;
      issue_cnt_q      <= '0;
      processing_cnt_q <= '0;
      commit_cnt_q     <= '0;
      issue_rem_q      <= '0;
      proc_rem_q       <= '0;
      commit_rem_q     <= '0;
    end else begin
      accept_pnt_q     <= accept_pnt_d;
      issue_pnt_q      <= issue_pnt_d;
      processing_pnt_q <= processing_pnt_d;
      commit_pnt_q     <= commit_pnt_d;
      issue_cnt_q      <= issue_cnt_d;
      processing_cnt_q <= processing_cnt_d;
      commit_cnt_q     <= commit_cnt_d;
      issue_rem_q      <= issue_rem_d;
      proc_rem_q       <= proc_rem_d;
      commit_rem_q     <= commit_rem_d;
    end
  end

endmodule

//--- src/simd_mul.sv
// Pipelined SIMD multiply-accumulate on one 64-bit word
// The element width travels with each beat; all stages stall together

`include "vmul_config.svh"

module simd_mul (
  input  logic               clk_i,
  input  logic               rst_ni,
  input  logic               valid_i,
  output logic               ready_o,
  input  vmul_pkg::elen_t    a_i,
  input  vmul_pkg::elen_t    b_i,
  input  vmul_pkg::elen_t    c_i,
  input  vmul_pkg::mul_op_e  op_i,
  input  vmul_pkg::vew_e     vsew_i,
  output vmul_pkg::elen_t    result_o,
  output logic               valid_o,
  input  logic               ready_i
);

  import vmul_pkg::*;

  elen_t                prod_d;
  elen_t                prod_q [`MUL_LAT];
  elen_t                acc_q  [`MUL_LAT];
  mul_op_e              op_q   [`MUL_LAT];
  vew_e                 vsew_q [`MUL_LAT];
  logic [`MUL_LAT-1:0]  valid_q;
  logic                 advance;
  elen_t                msb, last_c, last_p;

  // Hold everything while the last stage waits for its consumer
  assign advance = ready_i || !valid_q[`MUL_LAT-1];
  assign ready_o = advance;

  //////////////////////////////////////////////////
  // Per-element low products
  //////////////////////////////////////////////////

  always_comb begin
    prod_d = '0;
    case (vsew_i)
      EW8: begin
        for (int i = 0; i < 8; i++) prod_d[8*i +: 8] = a_i[8*i +: 8] * b_i[8*i +: 8];
      end
      EW16: begin
        for (int i = 0; i < 4; i++) prod_d[16*i +: 16] = a_i[16*i +: 16] * b_i[16*i +: 16];
      end
      EW32: begin
        for (int i = 0; i < 2; i++) prod_d[32*i +: 32] = a_i[32*i +: 32] * b_i[32*i +: 32];
      end
      default: prod_d = a_i * b_i;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      valid_q <= '0;
    end else if (advance) begin
      valid_q[0] <= valid_i;
      for (int s = 1; s < `MUL_LAT; s++) valid_q[s] <= valid_q[s-1];
    end
  end

  always_ff @(posedge clk_i) begin
    if (advance) begin
      prod_q[0] <= prod_d;
      acc_q[0]  <= c_i;
      op_q[0]   <= op_i;
      vsew_q[0] <= vsew_i;
      for (int s = 1; s < `MUL_LAT; s++) begin
        prod_q[s] <= prod_q[s-1];
        acc_q[s]  <= acc_q[s-1];
        op_q[s]   <= op_q[s-1];
        vsew_q[s] <= vsew_q[s-1];
      end
    end
  end

  //////////////////////////////////////////////////
  // Accumulate with carries cut at element borders
  //////////////////////////////////////////////////

  assign last_c  = acc_q[`MUL_LAT-1];
  assign last_p  = prod_q[`MUL_LAT-1];
  assign valid_o = valid_q[`MUL_LAT-1];

  always_comb begin
    // Top bit of every element
    case (vsew_q[`MUL_LAT-1])
      EW8:     msb = {8{8'h80}};
      EW16:    msb = {4{16'h8000}};
      EW32:    msb = {2{32'h8000_0000}};
      default: msb = 64'h8000_0000_0000_0000;
    endcase
    case (op_q[`MUL_LAT-1])
      VMACC:   result_o = ((last_c & ~msb) + (last_p & ~msb)) ^ ((last_c ^ last_p) & msb);
      VNMSAC:  result_o = ((last_c | msb) - (last_p & ~msb)) ^ ((last_c ^ ~last_p) & msb);
      default: result_o = last_p;
    endcase
  end

endmodule

//--- src/result_queue.sv
// Result buffer between the multiplier and the vector register file
// Tags each word with its address and byte enable, then writes it out
// with a request/grant handshake

`include "vmul_config.svh"

module result_queue (
  input  logic                clk_i,
  input  logic                rst_ni,
  input  logic                res_valid_i,
  input  vmul_pkg::elen_t     res_data_i,
  output logic                res_ready_o,
  input  vmul_pkg::vmul_op_t  proc_op_i,
  input  vmul_pkg::vlen_t     proc_remaining_i,
  output logic                proc_beat_o,
  output logic                commit_o,
  output logic                result_req_o,
  output vmul_pkg::vid_t      result_id_o,
  output vmul_pkg::vaddr_t    result_addr_o,
  output vmul_pkg::elen_t     result_wdata_o,
  output vmul_pkg::strb_t     result_be_o,
  input  logic                result_gnt_i
);

  import vmul_pkg::*;

  localparam int unsigned depth = `RESULT_QUEUE_DEPTH;
  localparam int unsigned pnt_w = (depth > 1) ? $clog2(depth) : 1;

  typedef struct packed {
    vid_t   id;
    vaddr_t addr;
    elen_t  wdata;
    strb_t  be;
  } entry_t;

  entry_t           entry_q [depth];
  entry_t           new_entry;
  logic [pnt_w-1:0] wr_pnt_q, rd_pnt_q;
  logic [pnt_w:0]   cnt_q;
  logic             push, pop;
  vlen_t            n_elems, word_idx;
  logic [3:0]       n_bytes;

  assign res_ready_o = (cnt_q != (pnt_w + 1)'(depth));
  assign push        = res_valid_i && res_ready_o;
  assign proc_beat_o = push;

  // Word index is the count of elements already processed, in words
  always_comb begin
    n_elems = vlen_t'(elems_per_word(proc_op_i.vsew));
    if (n_elems > proc_remaining_i) n_elems = proc_remaining_i;
    n_bytes  = 4'(n_elems << proc_op_i.vsew);
    word_idx = (proc_op_i.vl - proc_remaining_i) >> (2'd3 - proc_op_i.vsew);

    new_entry.id    = proc_op_i.id;
    new_entry.addr  = vaddr_t'(proc_op_i.vd * `VREG_WORDS + word_idx);
    new_entry.wdata = res_data_i;
    new_entry.be    = strb_t'(8'hff >> (4'd8 - n_bytes));
  end

  //////////////////////////////////////////////////
  // Register file write port
  //////////////////////////////////////////////////

  assign result_req_o   = (cnt_q != '0);
  assign result_id_o    = entry_q[rd_pnt_q].id;
  assign result_addr_o  = entry_q[rd_pnt_q].addr;
  assign result_wdata_o = entry_q[rd_pnt_q].wdata;
  assign result_be_o    = entry_q[rd_pnt_q].be;
  assign pop            = result_req_o && result_gnt_i;
  assign commit_o       = pop;

  always_ff @(posedge clk_i) begin
    if (push) begin
      entry_q[wr_pnt_q] <= new_entry;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_pnt_q <= '0;
      rd_pnt_q <= '0;
      cnt_q    <= '0;
    end else begin
      if (push) wr_pnt_q <= (wr_pnt_q == pnt_w'(depth - 1)) ? '0 : wr_pnt_q + 1'b1;
      if (pop) rd_pnt_q <= (rd_pnt_q == pnt_w'(depth - 1)) ? '0 : rd_pnt_q + 1'b1;
      case ({push, pop})
        2'b10:   cnt_q <= cnt_q + 1'b1;
        2'b01:   cnt_q <= cnt_q - 1'b1;
        default: cnt_q <= cnt_q;
      endcase
    end
  end

endmodule

//--- src/vmul_unit.sv
// Top of the vector lane integer multiply unit
// Sequencer feeds the SIMD multiplier, whose results drain through the
// result queue into the register file

`include "vmul_config.svh"

module vmul_unit (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  input  vmul_pkg::vmul_op_t    op_i,
  input  logic                  op_valid_i,
  output logic                  op_ready_o,
  input  vmul_pkg::elen_t       operand_i       [3],
  input  logic                  operand_valid_i [3],
  output logic                  operand_ready_o [3],
  output logic                  result_req_o,
  output vmul_pkg::vid_t        result_id_o,
  output vmul_pkg::vaddr_t      result_addr_o,
  output vmul_pkg::elen_t       result_wdata_o,
  output vmul_pkg::strb_t       result_be_o,
  input  logic                  result_gnt_i,
  output logic [`NR_VINSN-1:0]  vinsn_done_o
);

  import vmul_pkg::*;

  // Sequencer to multiplier
  logic     mul_valid, mul_ready;
  elen_t    mul_a, mul_b, mul_c;
  mul_op_e  mul_op;
  vew_e     mul_vsew;
  // Multiplier to result queue
  logic     res_valid, res_ready;
  elen_t    res_data;
  // Bookkeeping between result queue and sequencer
  vmul_op_t proc_op;
  vlen_t    proc_remaining;
  logic     proc_beat, commit;

  vmul_sequencer i_sequencer (
    .clk_i, .rst_ni, .op_i, .op_valid_i, .op_ready_o,
    .operand_i, .operand_valid_i, .operand_ready_o,
    .mul_valid_o (mul_valid), .mul_a_o (mul_a), .mul_b_o (mul_b), .mul_c_o (mul_c),
    .mul_op_o (mul_op), .mul_vsew_o (mul_vsew), .mul_ready_i (mul_ready),
    .proc_op_o (proc_op), .proc_remaining_o (proc_remaining), .proc_beat_i (proc_beat),
    .commit_i (commit), .vinsn_done_o
  );

  simd_mul i_simd_mul (
    .clk_i, .rst_ni,
    .valid_i (mul_valid), .ready_o (mul_ready),
    .a_i (mul_a), .b_i (mul_b), .c_i (mul_c), .op_i (mul_op), .vsew_i (mul_vsew),
    .result_o (res_data), .valid_o (res_valid), .ready_i (res_ready)
  );

  result_queue i_result_queue (
    .clk_i, .rst_ni,
    .res_valid_i (res_valid), .res_data_i (res_data), .res_ready_o (res_ready),
    .proc_op_i (proc_op), .proc_remaining_i (proc_remaining), .proc_beat_o (proc_beat),
    .commit_o (commit),
    .result_req_o, .result_id_o, .result_addr_o, .result_wdata_o, .result_be_o,
    .result_gnt_i
  );

endmodule

//--- sim/vmul_unit_props.sv
// Handshake checks for the vector multiply unit
// Bound into the top so every simulation of it carries them

module vmul_unit_props (
  input logic               clk_i,
  input logic               rst_ni,
  input logic               operand_valid_i [3],
  input logic               operand_ready_o [3],
  input logic               result_req_o,
  input logic               result_gnt_i,
  input vmul_pkg::vid_t     result_id_o,
  input vmul_pkg::vaddr_t   result_addr_o,
  input vmul_pkg::elen_t    result_wdata_o,
  input vmul_pkg::strb_t    result_be_o
);

  // Pending write holds until granted
  req_stable: assert property (@(posedge clk_i) disable iff (!rst_ni)
    result_req_o && !result_gnt_i |=> result_req_o && $stable(result_id_o) &&
    $stable(result_addr_o) && $stable(result_wdata_o) && $stable(result_be_o))
    else $error("Register file request changed before its grant");

  // Operand pops only from queues that offer a word
  vs1_pop: assert property (@(posedge clk_i) disable iff (!rst_ni)
    operand_ready_o[0] |-> operand_valid_i[0]) else $error("vs1 popped while empty");
  vs2_pop: assert property (@(posedge clk_i) disable iff (!rst_ni)
    operand_ready_o[1] |-> operand_valid_i[1]) else $error("vs2 popped while empty");
  vd_pop: assert property (@(posedge clk_i) disable iff (!rst_ni)
    operand_ready_o[2] |-> operand_valid_i[2]) else $error("vd popped while empty");

  no_req_after_reset: assert property (@(posedge clk_i) $rose(rst_ni) |-> !result_req_o)
    else $error("Register file request high right after reset");

endmodule

bind vmul_unit vmul_unit_props i_props (
  .clk_i           (clk_i),
  .rst_ni          (rst_ni),
  .operand_valid_i (operand_valid_i),
  .operand_ready_o (operand_ready_o),
  .result_req_o    (result_req_o),
  .result_gnt_i    (result_gnt_i),
  .result_id_o     (result_id_o),
  .result_addr_o   (result_addr_o),
  .result_wdata_o  (result_wdata_o),
  .result_be_o     (result_be_o)
);

//--- sim/tb_vmul_unit.sv
// Testbench for the vector integer multiply unit
// Queues multiply operations with random operands, models the expected
// register file writes and checks every granted write and done pulse

`include "vmul_config.svh"

module tb_vmul_unit;

  import vmul_pkg::*;

  typedef struct packed {
    vid_t   id;
    vaddr_t addr;
    elen_t  data;
    strb_t  be;
    logic   last;
  } exp_t;

  logic                 clk_i;
  logic                 rst_ni;
  vmul_op_t             op_i;
  logic                 op_valid_i;
  logic                 op_ready_o;
  elen_t                operand_i       [3];
  logic                 operand_valid_i [3];
  logic                 operand_ready_o [3];
  logic                 result_req_o;
  vid_t                 result_id_o;
  vaddr_t               result_addr_o;
  elen_t                result_wdata_o;
  strb_t                result_be_o;
  logic                 result_gnt_i;
  logic [`NR_VINSN-1:0] vinsn_done_o;

  integer seed = 32'hcde2;
  int     errors = 0;
  int     word_limit = 0;
  int     cycles;
  int     n_ops = 0;
  int     gnt_mode = 0;
  logic   gaps = 1'b0;
  // Operand words per queue (0 = vs1, 1 = vs2, 2 = vd)
  elen_t  src_mem [3][512];
  int     src_wr [3] = '{0, 0, 0};
  int     src_rd [3] = '{0, 0, 0};
  exp_t   exp_q [$];

  vmul_unit DUT (
    .clk_i, .rst_ni, .op_i, .op_valid_i, .op_ready_o,
    .operand_i, .operand_valid_i, .operand_ready_o,
    .result_req_o, .result_id_o, .result_addr_o, .result_wdata_o, .result_be_o,
    .result_gnt_i, .vinsn_done_o
  );

  initial begin
    clk_i = 1'b0;
    forever #50 clk_i = ~clk_i;
  end

  //////////////////////////////////////////////////
  // Reference model
  //////////////////////////////////////////////////

  function automatic elen_t expected_word(mul_op_e op, int ew, elen_t a, elen_t b, elen_t c);
    elen_t mask, res, ea, eb, ec, p, r;
    res  = '0;
    mask = (ew == 64) ? '1 : ((64'd1 << ew) - 64'd1);
    for (int i = 0; i < 64 / ew; i++) begin
      ea = (a >> (i * ew)) & mask;
      eb = (b >> (i * ew)) & mask;
      ec = (c >> (i * ew)) & mask;
      p  = ea * eb;
      case (op)
        VMACC:   r = ec + p;
        VNMSAC:  r = ec - p;
        default: r = p;
      endcase
      res = res | ((r & mask) << (i * ew));
    end
    return res;
  endfunction

  // Low element of the scalar copied into every lane
  function automatic elen_t replicate_scalar(elen_t s, int ew);
    elen_t mask, res;
    res  = '0;
    mask = (ew == 64) ? '1 : ((64'd1 << ew) - 64'd1);
    for (int i = 0; i < 64 / ew; i++) res = res | ((s & mask) << (i * ew));
    return res;
  endfunction

  function automatic strb_t byte_enable(int n_bytes);
    strb_t be;
    be = '0;
    for (int i = 0; i < n_bytes; i++) be[i] = 1'b1;
    return be;
  endfunction

  function automatic elen_t rand_word();
    return {$random(seed), $random(seed)};
  endfunction

  task automatic check_value(string name, elen_t got, elen_t want);
    if (got !== want) begin
      $display("[ERROR] %0t: %s is %h, expected %h", $time, name, got, want);
      errors++;
    end
  endtask

  //////////////////////////////////////////////////
  // Stimulus
  //////////////////////////////////////////////////

  task automatic send_op(vmul_op_t op);
    @(posedge clk_i);
    op_i       <= op;
    op_valid_i <= 1'b1;
    @(posedge clk_i);
    while (!op_ready_o) @(posedge clk_i);
    op_valid_i <= 1'b0;
  endtask

  // Draws the operand words, queues the expected writes, then hands the op over
  task automatic run_op(mul_op_e op, vew_e vsew, int vl, int vd, logic use_scalar);
    vmul_op_t d;
    elen_t    a, b, c;
    exp_t     e;
    int       ew, n_el, words, rem;
    ew           = 8 << int'(vsew);
    n_el         = 8 >> int'(vsew);
    words        = (vl + n_el - 1) / n_el;
    d.id         = vid_t'(n_ops);
    d.op         = op;
    d.vsew       = vsew;
    d.vl         = vlen_t'(vl);
    d.vd         = 5'(vd);
    d.use_scalar = use_scalar;
    d.use_vd     = (op != VMUL);
    d.scalar_op  = rand_word();
    for (int k = 0; k < words; k++) begin
      a = use_scalar ? replicate_scalar(d.scalar_op, ew) : rand_word();
      b = rand_word();
      c = d.use_vd ? rand_word() : '0;
      if (!use_scalar) begin
        src_mem[0][src_wr[0]] = a;
        src_wr[0]++;
      end
      src_mem[1][src_wr[1]] = b;
      src_wr[1]++;
      if (d.use_vd) begin
        src_mem[2][src_wr[2]] = c;
        src_wr[2]++;
      end
      rem = vl - k * n_el;
      if (rem > n_el) rem = n_el;
      e.id   = d.id;
      e.addr = vaddr_t'(vd * `VREG_WORDS + k);
      e.data = expected_word(op, ew, a, b, c);
      e.be   = byte_enable(rem * ew / 8);
      e.last = (k == words - 1);
      exp_q.push_back(e);
    end
    word_limit += words;
    n_ops++;
    send_op(d);
  endtask

  task automatic wait_drain();
    while (exp_q.size() != 0) @(posedge clk_i);
    repeat (2) @(posedge clk_i);
  endtask

  // Operand queues, with random gaps when enabled
  always @(posedge clk_i) begin
    int   r;
    logic hold;
    for (int q = 0; q < 3; q++) begin
      r = $random(seed);
      if (!rst_ni) begin
        operand_valid_i[q] <= 1'b0;
      end else begin
        if (operand_valid_i[q] && operand_ready_o[q]) src_rd[q]++;
        hold = operand_valid_i[q] && !operand_ready_o[q];
        if (!hold) begin
          if (src_rd[q] < src_wr[q] && (!gaps || r[0])) begin
            operand_valid_i[q] <= 1'b1;
            operand_i[q]       <= src_mem[q][src_rd[q]];
          end else begin
            operand_valid_i[q] <= 1'b0;
          end
        end
      end
    end
  end

  // Grant always, never, or at random
  always @(posedge clk_i) begin
    int r;
    r = $random(seed);
    if (gnt_mode == 0) result_gnt_i <= 1'b1;
    else if (gnt_mode == 1) result_gnt_i <= 1'b0;
    else result_gnt_i <= r[0];
  end

  //////////////////////////////////////////////////
  // Comparison of register file writes
  //////////////////////////////////////////////////

  always @(posedge clk_i) begin
    exp_t                 e;
    logic [`NR_VINSN-1:0] done_exp;
    done_exp = '0;
    if (rst_ni && result_req_o && result_gnt_i) begin
      if (exp_q.size() == 0) begin
        $display("Unexpected register file write at time %0t to address %0d",
                 $time, result_addr_o);
        errors++;
      end else begin
        e = exp_q.pop_front();
        check_value("result_id_o", result_id_o, e.id);
        check_value("result_addr_o", result_addr_o, e.addr);
        check_value("result_wdata_o", result_wdata_o, e.data);
        check_value("result_be_o", result_be_o, e.be);
        if (e.last) done_exp[e.id] = 1'b1;
      end
    end
    if (rst_ni) check_value("vinsn_done_o", vinsn_done_o, done_exp);
  end

  initial begin
    cycles = 0;
    while (cycles <= 40 * word_limit + 200) begin
      @(posedge clk_i);
      cycles++;
    end
    $display("Timeout: run stopped after %0d cycles with %0d writes still missing and %0d errors",
             cycles, exp_q.size(), errors);
    $display("Test failures found");
    $finish;
  end

  initial begin
    int r;
    int n_el;
    rst_ni       = 1'b0;
    op_i         = '0;
    op_valid_i   = 1'b0;
    result_gnt_i = 1'b0;
    for (int q = 0; q < 3; q++) begin
      operand_i[q]       = '0;
      operand_valid_i[q] = 1'b0;
    end
    repeat (4) @(posedge clk_i);
    rst_ni <= 1'b1;
    @(posedge clk_i);
    check_value("op_ready_o", op_ready_o, 1);

    // Plain products at every element width
    for (int w = 0; w < 4; w++) run_op(VMUL, vew_e'(w), 3 * (8 >> w), 2 + w, 1'b0);
    // Accumulate forms and scalar operands
    run_op(VMACC, EW16, 12, 8, 1'b0);
    run_op(VNMSAC, EW32, 6, 9, 1'b0);
    run_op(VMUL, EW8, 16, 10, 1'b1);
    run_op(VNMSAC, EW64, 2, 11, 1'b1);
    // Partial last words
    run_op(VMUL, EW8, 13, 12, 1'b0);
    run_op(VMACC, EW16, 7, 13, 1'b0);
    run_op(VMUL, EW32, 5, 14, 1'b1);
    run_op(VNMSAC, EW8, 3, 15, 1'b0);
    wait_drain();

    // Queue full while nothing is granted
    gnt_mode = 1;
    run_op(VMUL, EW16, 9, 16, 1'b0);
    run_op(VMACC, EW8, 20, 17, 1'b1);
    run_op(VNMSAC, EW32, 4, 18, 1'b0);
    run_op(VMUL, EW64, 3, 19, 1'b0);
    @(posedge clk_i);
    check_value("op_ready_o", op_ready_o, 0);
    repeat (5) @(posedge clk_i);
    gnt_mode = 0;
    wait_drain();

    // Random ops under random grant and operand gaps
    gnt_mode = 2;
    gaps     = 1'b1;
    for (int n = 0; n < 12; n++) begin
      r    = $random(seed);
      n_el = 8 >> r[1:0];
      run_op((r[3:2] == 2'd3) ? VMUL : mul_op_e'(r[3:2]), vew_e'(r[1:0]),
             1 + int'(r[15:8]) % (4 * n_el), int'(r[20:16]) % 28, r[24]);
    end
    wait_drain();

    for (int q = 0; q < 3; q++) begin
      if (src_rd[q] != src_wr[q]) begin
        $display("Operand queue %0d consumed %0d of %0d words", q, src_rd[q], src_wr[q]);
        errors++;
      end
    end
    $display("Checks finished with %0d errors", errors);
    if (errors == 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

endmodule

//--- src.f
+incdir+src
src/vmul_pkg.sv
src/vmul_sequencer.sv
src/simd_mul.sv
src/result_queue.sv
src/vmul_unit.sv
sim/vmul_unit_props.sv
sim/tb_vmul_unit.sv

//--- Makefile
# Verilator build and run of the vector multiply unit testbench

VERILATOR ?= verilator
TOP       ?= tb_vmul_unit
FILELIST  ?= src.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0 -Wno-fatal
PASS_MSG  ?= All tests passed!

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qF '$(PASS_MSG)'

clean:
	rm -rf $(OBJ_DIR)
